// ==== cpu_pkg.sv ====
/* Shared types, field positions and sizes for the single-cycle core
   Opcodes 13 to 31 have no entry and decode as nop */
package cpu_pkg;

	// Datapath widths
	localparam int DataWidth   = 32;
	localparam int RegAdrWidth = 5;
	localparam int RegCount    = 32;
	localparam int PcWidth     = 9;
	localparam int ImmWidth    = 16;
	localparam int OpcodeWidth = 5;
	localparam int ShiftWidth  = 5;

	// Instruction field positions, MSB of each field
	localparam int OpcodeMsb = 31;
	localparam int ImmSelBit = 26;
	localparam int RdMsb     = 25;
	localparam int Rs1Msb    = 20;
	localparam int Rs0Msb    = 15;

	// Data memory, word addressed by ALU result bits 7..2
	localparam int DmemWords    = 64;
	localparam int DmemAdrWidth = $clog2(DmemWords);
	localparam int DmemAdrLsb   = 2;

	// Program counter stepping and jump target field
	localparam int PcStep      = 4;
	localparam int TargetWidth = PcWidth - 2;

	typedef enum logic [OpcodeWidth-1:0] {
		opNop = 5'd0,
		opAdd = 5'd1,
		opSub = 5'd2,
		opAnd = 5'd3,
		opOr  = 5'd4,
		opXor = 5'd5,
		opSlt = 5'd6,
		opSll = 5'd7,
		opLw  = 5'd8,
		opSw  = 5'd9,
		opJ   = 5'd10,
		opJr  = 5'd11,
		opBgt = 5'd12
	} opcodeT;

	typedef enum logic [2:0] {
		aluPass = 3'd0,
		aluAdd  = 3'd1,
		aluSub  = 3'd2,
		aluAnd  = 3'd3,
		aluOr   = 3'd4,
		aluXor  = 3'd5,
		aluSlt  = 3'd6,
		aluSll  = 3'd7
	} aluOpT;

endpackage

// ==== instrDecode.sv ====
/* Combinational decode of one instruction word
   Unknown opcodes produce the same controls as nop */
`timescale 1ns/10ps
module instrDecode (
	input  logic [cpu_pkg::DataWidth-1:0]   instr,
	output logic [cpu_pkg::RegAdrWidth-1:0] rdAdr,
	output logic [cpu_pkg::RegAdrWidth-1:0] rs1Adr,
	output logic [cpu_pkg::RegAdrWidth-1:0] rs0Adr,
	output logic [cpu_pkg::ImmWidth-1:0]    imm,
	output cpu_pkg::aluOpT                  aluCtl,
	output logic                            bSelImm,
	output logic                            wbEn,
	output logic                            memWrEn,
	output logic                            memToReg,
	output logic                            jump,
	output logic                            jumpReg,
	output logic                            branchCond
);

	cpu_pkg::opcodeT opcode;
	logic            immSel;

	// Field split, imm overlaps the source 0 field
	assign opcode = cpu_pkg::opcodeT'(instr[cpu_pkg::OpcodeMsb -: cpu_pkg::OpcodeWidth]);
	assign immSel = instr[cpu_pkg::ImmSelBit];
	assign rdAdr  = instr[cpu_pkg::RdMsb -: cpu_pkg::RegAdrWidth];
	assign rs1Adr = instr[cpu_pkg::Rs1Msb -: cpu_pkg::RegAdrWidth];
	assign rs0Adr = instr[cpu_pkg::Rs0Msb -: cpu_pkg::RegAdrWidth];
	assign imm    = instr[cpu_pkg::ImmWidth-1:0];

	always_comb begin
		// Defaults describe a nop
		aluCtl     = cpu_pkg::aluPass;
		bSelImm    = 1'b0;
		wbEn       = 1'b0;
		memWrEn    = 1'b0;
		memToReg   = 1'b0;
		jump       = 1'b0;
		jumpReg    = 1'b0;
		branchCond = 1'b0;
		case (opcode)
			cpu_pkg::opAdd: begin
				aluCtl  = cpu_pkg::aluAdd;
				bSelImm = immSel;
				wbEn    = 1'b1;
			end
			cpu_pkg::opSub: begin
				aluCtl  = cpu_pkg::aluSub;
				bSelImm = immSel;
				wbEn    = 1'b1;
			end
			cpu_pkg::opAnd: begin
				aluCtl  = cpu_pkg::aluAnd;
				bSelImm = immSel;
				wbEn    = 1'b1;
			end
			cpu_pkg::opOr: begin
				aluCtl  = cpu_pkg::aluOr;
				bSelImm = immSel;
				wbEn    = 1'b1;
			end
			cpu_pkg::opXor: begin
				aluCtl  = cpu_pkg::aluXor;
				bSelImm = immSel;
				wbEn    = 1'b1;
			end
			cpu_pkg::opSlt: begin
				aluCtl  = cpu_pkg::aluSlt;
				bSelImm = immSel;
				wbEn    = 1'b1;
			end
			cpu_pkg::opSll: begin
				aluCtl  = cpu_pkg::aluSll;
				bSelImm = immSel;
				wbEn    = 1'b1;
			end
			// Address is always source 0 plus imm
			cpu_pkg::opLw: begin
				aluCtl   = cpu_pkg::aluAdd;
				bSelImm  = 1'b1;
				wbEn     = 1'b1;
				memToReg = 1'b1;
			end
			cpu_pkg::opSw: begin
				aluCtl  = cpu_pkg::aluAdd;
				bSelImm = 1'b1;
				memWrEn = 1'b1;
			end
			cpu_pkg::opJ: begin
				jump = 1'b1;
			end
			cpu_pkg::opJr: begin
				aluCtl  = cpu_pkg::aluAdd;
				bSelImm = 1'b1;
				jumpReg = 1'b1;
			end
			// Compare by subtraction, the PC unit reads the sign
			cpu_pkg::opBgt: begin
				aluCtl     = cpu_pkg::aluSub;
				branchCond = 1'b1;
			end
			default: begin
				aluCtl = cpu_pkg::aluPass;
			end
		endcase
	end

endmodule

// ==== regFile.sv ====
/* 32 x 32 register file, two asynchronous reads, one synchronous write
   Register 0 ignores writes and always reads zero */
`timescale 1ns/10ps
module regFile (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            wrEn,
	input  logic [cpu_pkg::RegAdrWidth-1:0] wrAdr,
	input  logic [cpu_pkg::DataWidth-1:0]   wrData,
	input  logic [cpu_pkg::RegAdrWidth-1:0] rdAdrA,
	input  logic [cpu_pkg::RegAdrWidth-1:0] rdAdrB,
	output logic [cpu_pkg::DataWidth-1:0]   rdDataA,
	output logic [cpu_pkg::DataWidth-1:0]   rdDataB
);

	logic [cpu_pkg::DataWidth-1:0] regs [cpu_pkg::RegCount];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < cpu_pkg::RegCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (wrAdr != '0)) begin
			regs[wrAdr] <= wrData;
		end
	end

	// Same-cycle write is not forwarded
	assign rdDataA = regs[rdAdrA];
	assign rdDataB = regs[rdAdrB];

endmodule

// ==== alu.sv ====
/* Eight-operation ALU, purely combinational
   neg is the result sign bit, signed overflow is not corrected */
`timescale 1ns/10ps
module alu (
	input  logic [cpu_pkg::DataWidth-1:0] a,
	input  logic [cpu_pkg::DataWidth-1:0] b,
	input  cpu_pkg::aluOpT                op,
	output logic [cpu_pkg::DataWidth-1:0] result,
	output logic                          neg
);

	logic lessThan;

	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			cpu_pkg::aluPass: begin
				result = b;
			end
			cpu_pkg::aluAdd: begin
				result = a + b;
			end
			cpu_pkg::aluSub: begin
				result = a - b;
			end
			cpu_pkg::aluAnd: begin
				result = a & b;
			end
			cpu_pkg::aluOr: begin
				result = a | b;
			end
			cpu_pkg::aluXor: begin
				result = a ^ b;
			end
			cpu_pkg::aluSlt: begin
				result = {{(cpu_pkg::DataWidth-1){1'b0}}, lessThan};
			end
			// Shift amount from low bits of b only
			cpu_pkg::aluSll: begin
				result = a << b[cpu_pkg::ShiftWidth-1:0];
			end
			default: begin
				result = b;
			end
		endcase
	end

	assign neg = result[cpu_pkg::DataWidth-1];

endmodule

// ==== dataMem.sv ====
/* 64-word data memory, word addressed
   Synchronous write, combinational read, contents cleared in reset */
`timescale 1ns/10ps
module dataMem (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             wrEn,
	input  logic [cpu_pkg::DmemAdrWidth-1:0] adr,
	input  logic [cpu_pkg::DataWidth-1:0]    wrData,
	output logic [cpu_pkg::DataWidth-1:0]    rdData
);

	logic [cpu_pkg::DataWidth-1:0] mem [cpu_pkg::DmemWords];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < cpu_pkg::DmemWords; i++) begin
				mem[i] <= '0;
			end
		end else if (wrEn) begin
			mem[adr] <= wrData;
		end
	end

	assign rdData = mem[adr];

endmodule

// ==== pcUnit.sv ====
/* Program counter and next-address select
   Targets come from 7 bits shifted left by 2, so they stay inside 512 bytes */
`timescale 1ns/10ps
module pcUnit (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          advance,
	input  logic                          jump,
	input  logic                          jumpReg,
	input  logic                          branchCond,
	input  logic                          neg,
	input  logic [cpu_pkg::ImmWidth-1:0]  imm,
	input  logic [cpu_pkg::DataWidth-1:0] aluResult,
	output logic [cpu_pkg::PcWidth-1:0]   pc,
	output logic [cpu_pkg::PcWidth-1:0]   nextPc
);

	logic branchTaken;

	// Negative source 1 minus source 0 means source 0 is greater
	assign branchTaken = branchCond && neg;

	always_comb begin
		if (jump || branchTaken) begin
			nextPc = {imm[cpu_pkg::TargetWidth-1:0], 2'b00};
		end else if (jumpReg) begin
			nextPc = {aluResult[cpu_pkg::TargetWidth-1:0], 2'b00};
		end else begin
			nextPc = pc + cpu_pkg::PcWidth'(cpu_pkg::PcStep);
		end
	end

	// PC holds on bubbles
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (advance) begin
			pc <= nextPc;
		end
	end

endmodule

// ==== cpuTop.sv ====
/* Single-cycle core, instruction word arrives over a valid/ready channel
   Each accepted instruction shows up on the retire trace one cycle later */
`timescale 1ns/10ps
module cpuTop (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             instrValid,
	input  logic [cpu_pkg::DataWidth-1:0]    instr,
	output logic                             instrReady,
	output logic [cpu_pkg::PcWidth-1:0]      pc,
	output logic                             retValid,
	output logic [cpu_pkg::PcWidth-1:0]      retPc,
	output logic                             retWbEn,
	output logic [cpu_pkg::RegAdrWidth-1:0]  retWbAdr,
	output logic [cpu_pkg::DataWidth-1:0]    retWbData,
	output logic                             retMemWr,
	output logic [cpu_pkg::DmemAdrWidth-1:0] retMemAdr,
	output logic [cpu_pkg::DataWidth-1:0]    retMemData,
	output logic [cpu_pkg::PcWidth-1:0]      retNextPc
);

	logic                             accept;
	logic [cpu_pkg::RegAdrWidth-1:0]  rdAdr;
	logic [cpu_pkg::RegAdrWidth-1:0]  rs1Adr;
	logic [cpu_pkg::RegAdrWidth-1:0]  rs0Adr;
	logic [cpu_pkg::ImmWidth-1:0]     imm;
	cpu_pkg::aluOpT                   aluCtl;
	logic                             bSelImm;
	logic                             wbEn;
	logic                             memWrEn;
	logic                             memToReg;
	logic                             jump;
	logic                             jumpReg;
	logic                             branchCond;
	logic [cpu_pkg::DataWidth-1:0]    rs0Data;
	logic [cpu_pkg::DataWidth-1:0]    rs1Data;
	logic [cpu_pkg::DataWidth-1:0]    immExt;
	logic [cpu_pkg::DataWidth-1:0]    aluA;
	logic [cpu_pkg::DataWidth-1:0]    aluB;
	logic [cpu_pkg::DataWidth-1:0]    aluResult;
	logic                             aluNeg;
	logic [cpu_pkg::DmemAdrWidth-1:0] memAdr;
	logic [cpu_pkg::DataWidth-1:0]    memRdData;
	logic [cpu_pkg::DataWidth-1:0]    wbData;
	logic [cpu_pkg::PcWidth-1:0]      nextPc;

	// No internal stall source, ready once out of reset
	always_ff @(posedge clk) begin
		if (rst) begin
			instrReady <= 1'b0;
		end else begin
			instrReady <= 1'b1;
		end
	end

	assign accept = instrValid && instrReady;

	instrDecode uDecode (
		.instr(instr),
		.rdAdr(rdAdr),
		.rs1Adr(rs1Adr),
		.rs0Adr(rs0Adr),
		.imm(imm),
		.aluCtl(aluCtl),
		.bSelImm(bSelImm),
		.wbEn(wbEn),
		.memWrEn(memWrEn),
		.memToReg(memToReg),
		.jump(jump),
		.jumpReg(jumpReg),
		.branchCond(branchCond)
	);

	regFile uRegFile (
		.clk(clk),
		.rst(rst),
		.wrEn(wbEn && accept),
		.wrAdr(rdAdr),
		.wrData(wbData),
		.rdAdrA(rs0Adr),
		.rdAdrB(rs1Adr),
		.rdDataA(rs0Data),
		.rdDataB(rs1Data)
	);

	assign immExt = {{(cpu_pkg::DataWidth-cpu_pkg::ImmWidth){imm[cpu_pkg::ImmWidth-1]}}, imm};

	// bgt swaps operands so the ALU computes source 1 minus source 0
	assign aluA = branchCond ? rs1Data : rs0Data;
	assign aluB = branchCond ? rs0Data : (bSelImm ? immExt : rs1Data);

	alu uAlu (
		.a(aluA),
		.b(aluB),
		.op(aluCtl),
		.result(aluResult),
		.neg(aluNeg)
	);

	assign memAdr = aluResult[cpu_pkg::DmemAdrLsb +: cpu_pkg::DmemAdrWidth];

	// Store data always comes from source 1
	dataMem uDataMem (
		.clk(clk),
		.rst(rst),
		.wrEn(memWrEn && accept),
		.adr(memAdr),
		.wrData(rs1Data),
		.rdData(memRdData)
	);

	assign wbData = memToReg ? memRdData : aluResult;

	pcUnit uPcUnit (
		.clk(clk),
		.rst(rst),
		.advance(accept),
		.jump(jump),
		.jumpReg(jumpReg),
		.branchCond(branchCond),
		.neg(aluNeg),
		.imm(imm),
		.aluResult(aluResult),
		.pc(pc),
		.nextPc(nextPc)
	);

	// Trace loads at the same edge as the register and memory writes
	always_ff @(posedge clk) begin
		if (rst) begin
			retValid <= 1'b0;
		end else begin
			retValid <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			retPc      <= pc;
			retWbEn    <= wbEn && (rdAdr != '0);
			retWbAdr   <= rdAdr;
			retWbData  <= wbData;
			retMemWr   <= memWrEn;
			retMemAdr  <= memAdr;
			retMemData <= rs1Data;
			retNextPc  <= nextPc;
		end
	end

endmodule

// ==== cpu_checker.sv ====
/* Concurrent checks on the cpuTop handshake and retire trace
   Bound into cpuTop, failures are counted for the testbench summary */
`timescale 1ns/10ps
module cpu_checker (
	input logic                            clk,
	input logic                            rst,
	input logic                            instrValid,
	input logic                            instrReady,
	input logic [cpu_pkg::PcWidth-1:0]     pc,
	input logic                            retValid,
	input logic                            retWbEn,
	input logic [cpu_pkg::RegAdrWidth-1:0] retWbAdr
);

	int   failCount = 0;
	logic accept;

	assign accept = instrValid && instrReady;

	// Trace follows acceptance by exactly one cycle
	retireFollows: assert property (@(posedge clk) disable iff (rst) accept |=> retValid)
		else begin
			failCount++;
			$error("retValid missing one cycle after an accepted instruction");
		end

	noSpuriousRetire: assert property (@(posedge clk) disable iff (rst) !accept |=> !retValid)
		else begin
			failCount++;
			$error("retValid high without an accepted instruction");
		end

	readyLowInReset: assert property (@(posedge clk) (rst && $past(rst)) |-> !instrReady)
		else begin
			failCount++;
			$error("instrReady high during reset");
		end

	// Bubbles leave the pc alone
	pcHoldsOnBubble: assert property (@(posedge clk) disable iff (rst) !accept |=> $stable(pc))
		else begin
			failCount++;
			$error("pc changed across a bubble");
		end

	noWriteToZero: assert property (@(posedge clk) disable iff (rst)
			(retValid && retWbEn) |-> (retWbAdr != '0))
		else begin
			failCount++;
			$error("retWbEn reported for register 0");
		end

endmodule

// ==== tb_cpu.sv ====
/* Testbench for cpuTop with a random program of forward-only jumps and an ISA model
   Runs until program word 127 retires, the watchdog bounds the run */
`timescale 1ns/10ps
module tb_cpu;

	localparam int ProgWords   = 128;
	localparam int ResetCycles = 16;
	localparam int PeriodNs    = 4;
	// At most three bubbles in a row, so each word takes at most 4 cycles
	localparam int WatchdogNs  = (ResetCycles + ProgWords * 4) * PeriodNs + 400;

	logic                             clk = 1'b0;
	logic                             rst;
	logic                             instrValid;
	logic [cpu_pkg::DataWidth-1:0]    instr;
	logic                             instrReady;
	logic [cpu_pkg::PcWidth-1:0]      pc;
	logic                             retValid;
	logic [cpu_pkg::PcWidth-1:0]      retPc;
	logic                             retWbEn;
	logic [cpu_pkg::RegAdrWidth-1:0]  retWbAdr;
	logic [cpu_pkg::DataWidth-1:0]    retWbData;
	logic                             retMemWr;
	logic [cpu_pkg::DmemAdrWidth-1:0] retMemAdr;
	logic [cpu_pkg::DataWidth-1:0]    retMemData;
	logic [cpu_pkg::PcWidth-1:0]      retNextPc;

	// Program and model state
	logic [31:0] seed = 32'd97;
	logic [31:0] prog [ProgWords];
	logic [6:0]  jrTarget [ProgWords];
	logic [5:0]  memWord [ProgWords];
	logic [31:0] mReg [32];
	logic [31:0] mMem [cpu_pkg::DmemWords];
	logic [8:0]  mPc;

	// Expected trace of the last accepted instruction
	logic        pending;
	logic [8:0]  expPc;
	logic        expWbEn;
	logic [4:0]  expWbAdr;
	logic [31:0] expWbData;
	logic        expMemWr;
	logic [5:0]  expMemAdr;
	logic [31:0] expMemData;
	logic [8:0]  expNextPc;

	int errorCount = 0;
	int retired    = 0;

	cpuTop DUT (.*);

	bind cpuTop cpu_checker uChecker (.*);

	always #(PeriodNs / 2) clk = ~clk;

	function automatic int rnd();
		seed = seed * 32'd1103515245 + 32'd12345;
		return int'({17'd0, seed[30:16]});
	endfunction

	// Forward target within the next 8 words
	function automatic logic [6:0] pickTarget(input int idx);
		int span;
		span = (ProgWords - 1 - idx < 8) ? ProgWords - 1 - idx : 8;
		return 7'(idx + 1 + rnd() % span);
	endfunction

	function automatic logic [31:0] genWord(input int idx);
		int          kind;
		logic [4:0]  op;
		logic        isImm;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs0;
		logic [15:0] imm;
		kind  = rnd() % 16;
		rd    = (rnd() % 16 == 0) ? 5'd0 : 5'(1 + rnd() % 7);
		rs1   = (rnd() % 16 == 0) ? 5'd0 : 5'(1 + rnd() % 7);
		rs0   = 5'(1 + rnd() % 7);
		isImm = 1'(rnd() % 2);
		imm   = {rs0, 11'(rnd())};
		// Last word has nowhere forward to go
		if (idx == ProgWords - 1 && kind >= 11 && kind <= 13) kind = 0;
		if (kind <= 6) begin
			op = 5'(kind + 1);
			if (isImm) imm = 16'(rnd() * 2 + rnd() % 2);
		end else if (kind <= 8) begin
			op           = cpu_pkg::opLw;
			memWord[idx] = 6'((rnd() % 8) * 9);
		end else if (kind <= 10) begin
			op           = cpu_pkg::opSw;
			memWord[idx] = 6'((rnd() % 8) * 9);
		end else if (kind == 11) begin
			op  = cpu_pkg::opJ;
			imm = {9'd0, pickTarget(idx)};
		end else if (kind == 12) begin
			op            = cpu_pkg::opJr;
			imm           = {rs0, 11'd0};
			jrTarget[idx] = pickTarget(idx);
		end else if (kind == 13) begin
			op  = cpu_pkg::opBgt;
			imm = {rs0, 4'd0, pickTarget(idx)};
		end else if (kind == 14) begin
			op = cpu_pkg::opNop;
		end else begin
			// Unused opcode space
			op = 5'(13 + rnd() % 19);
		end
		return {op, isImm, rd, rs1, imm};
	endfunction

	task automatic reportMismatch(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		errorCount++;
		$display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
	endtask

	// One instruction through the ISA rules
	task automatic stepModel(input logic [31:0] word);
		logic [4:0]  op;
		logic [4:0]  rd;
		logic [31:0] a;
		logic [31:0] s1;
		logic [31:0] sx;
		logic [31:0] b;
		logic [31:0] sum;
		logic [31:0] diff;
		logic [31:0] res;
		op         = word[31:27];
		rd         = word[25:21];
		a          = mReg[word[15:11]];
		s1         = mReg[word[20:16]];
		sx         = {{16{word[15]}}, word[15:0]};
		b          = word[26] ? sx : s1;
		sum        = a + sx;
		diff       = s1 - a;
		res        = '0;
		expPc      = mPc;
		expNextPc  = mPc + 9'd4;
		expMemWr   = 1'b0;
		expMemAdr  = sum[7:2];
		expMemData = s1;
		case (op)
			cpu_pkg::opAdd: res = a + b;
			cpu_pkg::opSub: res = a - b;
			cpu_pkg::opAnd: res = a & b;
			cpu_pkg::opOr:  res = a | b;
			cpu_pkg::opXor: res = a ^ b;
			cpu_pkg::opSlt: res = {31'd0, $signed(a) < $signed(b)};
			cpu_pkg::opSll: res = a << b[4:0];
			cpu_pkg::opLw:  res = mMem[sum[7:2]];
			cpu_pkg::opSw:  expMemWr = 1'b1;
			cpu_pkg::opJ:   expNextPc = {word[6:0], 2'b00};
			cpu_pkg::opJr:  expNextPc = {sum[6:0], 2'b00};
			// Taken when source 1 minus source 0 comes out negative
			cpu_pkg::opBgt: if (diff[31]) expNextPc = {word[6:0], 2'b00};
			default:        res = '0;
		endcase
		expWbEn   = (op >= 5'd1) && (op <= 5'd8) && (rd != 5'd0);
		expWbAdr  = rd;
		expWbData = res;
		if (expWbEn) mReg[rd] = res;
		if (expMemWr) mMem[expMemAdr] = s1;
		mPc     = expNextPc;
		pending = 1'b1;
	endtask

	task automatic checkTrace();
		if (instrReady !== 1'b1) reportMismatch("instrReady", 32'(instrReady), 32'd1);
		if (retValid !== pending) reportMismatch("retValid", 32'(retValid), 32'(pending));
		if (pending) begin
			if (retPc !== expPc) reportMismatch("retPc", 32'(retPc), 32'(expPc));
			if (retWbEn !== expWbEn) reportMismatch("retWbEn", 32'(retWbEn), 32'(expWbEn));
			if (expWbEn && retWbAdr !== expWbAdr)
				reportMismatch("retWbAdr", 32'(retWbAdr), 32'(expWbAdr));
			if (expWbEn && retWbData !== expWbData)
				reportMismatch("retWbData", retWbData, expWbData);
			if (retMemWr !== expMemWr) reportMismatch("retMemWr", 32'(retMemWr), 32'(expMemWr));
			if (expMemWr && retMemAdr !== expMemAdr)
				reportMismatch("retMemAdr", 32'(retMemAdr), 32'(expMemAdr));
			if (expMemWr && retMemData !== expMemData)
				reportMismatch("retMemData", retMemData, expMemData);
			if (retNextPc !== expNextPc)
				reportMismatch("retNextPc", 32'(retNextPc), 32'(expNextPc));
		end
		if (pc !== mPc) reportMismatch("pc", 32'(pc), 32'(mPc));
	endtask

	initial begin
		int   idx;
		int   gap;
		logic lastIssued;
		rst        <= 1'b1;
		instrValid <= 1'b0;
		instr      <= '0;
		mPc        = '0;
		pending    = 1'b0;
		gap        = 0;
		lastIssued = 1'b0;
		for (int i = 0; i < 32; i++) mReg[i] = '0;
		for (int i = 0; i < cpu_pkg::DmemWords; i++) mMem[i] = '0;
		for (int i = 0; i < ProgWords; i++) prog[i] = genWord(i);
		repeat (ResetCycles) @(posedge clk);
		rst <= 1'b0;
		do begin
			@(posedge clk);
			idx = int'(mPc[8:2]);
			// Aim jr at its forward target from the current register value
			if (prog[idx][31:27] == cpu_pkg::opJr)
				prog[idx][6:0] = jrTarget[idx] - mReg[prog[idx][15:11]][6:0];
			// Eight shared words spread over the memory so loads find earlier stores
			if (prog[idx][31:27] == cpu_pkg::opLw || prog[idx][31:27] == cpu_pkg::opSw)
				prog[idx][7:0] = {memWord[idx], 2'b00} - mReg[prog[idx][15:11]][7:0];
			instrValid <= !lastIssued && (gap >= 3 || rnd() % 4 != 0);
			instr      <= prog[idx];
			@(negedge clk);
			checkTrace();
			pending = 1'b0;
			if (instrValid) begin
				gap = 0;
				retired++;
				stepModel(instr);
				lastIssued = lastIssued || (idx == ProgWords - 1);
			end else begin
				gap++;
			end
		end while (!lastIssued || pending);
		$display("Retired %0d instructions, %0d trace mismatches, %0d assertion failures",
			retired, errorCount, DUT.uChecker.failCount);
		if (errorCount == 0 && DUT.uChecker.failCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		#(WatchdogNs);
		$display("Watchdog expired: the program did not retire within %0d ns", WatchdogNs);
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== files.f ====
cpu_pkg.sv
instrDecode.sv
regFile.sv
alu.sv
dataMem.sv
pcUnit.sv
cpuTop.sv
cpu_checker.sv
tb_cpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it, and look for the pass message
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_cpu -f files.f

# Raise the error limit so assertion failures do not stop the run early
output=$(./obj_dir/Vtb_cpu +verilator+error+limit+1000 || true)
echo "$output"

if grep -q "All tests passed!" <<< "$output"; then
	exit 0
fi
exit 1
